//--- filelist.f
prefetch_fifo_pkg.sv
sdp_ram.sv
fifo_ctrl.sv
out_reg_fifo.sv
prefetch_fifo.sv
tb_prefetch_fifo.sv

//--- tb_prefetch_fifo.sv
/*
  prefetch fifo testbench
  drives reset, first-word fall-through, fill to full, random traffic
  and streaming; a queue scoreboard models the FIFO contents and
  concurrent assertions compare the DUT against it every cycle
*/
`timescale 1ns/10ps

module tb_prefetch_fifo;

  localparam int dw         = prefetch_fifo_pkg::def_depth_width;  // RAM address width
  localparam int dwid       = prefetch_fifo_pkg::def_data_width;   // word width
  localparam int depth      = 1 << dw;                             // RAM words
  localparam int cap        = depth + 2;                           // RAM plus output stage
  localparam int af_lvl     = 12;
  localparam int ae_lvl     = 2;
  localparam int clk_period = 40;

  // cycle budgets per test, also used as wait limits
  localparam int t_reset  = 10;
  localparam int t_fwft   = 20;
  localparam int t_fill   = 40;
  localparam int t_drain  = 40;
  localparam int t_random = 600;
  localparam int t_stream = 80;
  localparam int total_cycles = t_reset + t_fwft + t_fill + t_random + t_stream + 4 * t_drain;

  logic                      rd_clk;
  logic                      rd_rst;
  logic [dwid-1:0]           wr_data;
  logic                      wr_en;
  logic                      wr_vld;
  logic [dwid-1:0]           rd_data;
  logic                      rd_en;
  logic                      rd_vld;
  logic                      almost_full;
  logic                      almost_empty;
  prefetch_fifo_pkg::level_t water_level;

  logic [dwid-1:0] sb [$];      // scoreboard, oldest first
  int              sb_count;    // words accepted and not yet popped
  logic [dwid-1:0] exp_head;    // oldest word in the model
  logic [dwid-1:0] held_data;   // rd_data seen at the last edge
  logic            chk_reset;   // one cycle after reset release
  logic            stream_on;   // streaming window
  int              err_count;
  int              pass_tests;
  int              fail_tests;
  int              test_errs;   // err_count at test start
  integer          seed;

  prefetch_fifo #(
    .depth_width (dw),
    .data_width  (dwid),
    .af_level    (af_lvl),
    .ae_level    (ae_lvl)
  ) uut (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .wr_data      (wr_data),
    .wr_en        (wr_en),
    .wr_vld       (wr_vld),
    .rd_data      (rd_data),
    .rd_en        (rd_en),
    .rd_vld       (rd_vld),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .water_level  (water_level)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #(clk_period / 2) rd_clk = ~rd_clk;
  end

  //////////////////////////////
  // scoreboard model
  //////////////////////////////

  always @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      sb.delete();
      sb_count  <= 0;
      exp_head  <= '0;
      held_data <= '0;
    end
    else
    begin
      if (rd_en && rd_vld && sb.size() > 0)
        void'(sb.pop_front());      // pop first, then push
      if (wr_en && wr_vld)
        sb.push_back(wr_data);
      sb_count  <= sb.size();
      exp_head  <= (sb.size() > 0) ? sb[0] : '0;
      held_data <= rd_data;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_reset_flags : assert property (@(posedge rd_clk)
    chk_reset |-> ({rd_vld, wr_vld, almost_full, almost_empty} == 4'h5))
    else begin
      err_count = err_count + 1;
      $display("FAILED {rd_vld,wr_vld,almost_full,almost_empty} expected 5 got %h",
               $sampled({rd_vld, wr_vld, almost_full, almost_empty}));
    end

  a_reset_level : assert property (@(posedge rd_clk) chk_reset |-> water_level == 0)
    else begin
      err_count = err_count + 1;
      $display("FAILED water_level expected 0 got %h", $sampled(water_level));
    end

  // E0 write, E1 issue, E2 load, seen high from E3
  a_fwft : assert property (@(posedge rd_clk) disable iff (rd_rst)
    (wr_en && wr_vld && sb_count == 0) |-> ##1 !rd_vld ##1 !rd_vld ##1 rd_vld)
    else begin
      err_count = err_count + 1;
      $display("rd_vld did not rise two cycles after a write into the empty FIFO");
    end

  a_wr_vld : assert property (@(posedge rd_clk) disable iff (rd_rst)
    wr_vld == (sb_count < cap))
    else begin
      err_count = err_count + 1;
      $display("FAILED wr_vld expected %h got %h (words held %0d)",
               $sampled(sb_count < cap), $sampled(wr_vld), $sampled(sb_count));
    end

  a_full_level : assert property (@(posedge rd_clk) disable iff (rd_rst)
    !wr_vld |-> water_level == depth)
    else begin
      err_count = err_count + 1;
      $display("FAILED water_level expected %h got %h", depth, $sampled(water_level));
    end

  a_almost_full : assert property (@(posedge rd_clk) disable iff (rd_rst)
    almost_full == (water_level >= af_lvl))
    else begin
      err_count = err_count + 1;
      $display("FAILED almost_full expected %h got %h",
               $sampled(water_level >= af_lvl), $sampled(almost_full));
    end

  a_almost_empty : assert property (@(posedge rd_clk) disable iff (rd_rst)
    almost_empty == (water_level <= ae_lvl))
    else begin
      err_count = err_count + 1;
      $display("FAILED almost_empty expected %h got %h",
               $sampled(water_level <= ae_lvl), $sampled(almost_empty));
    end

  a_no_phantom : assert property (@(posedge rd_clk) disable iff (rd_rst)
    rd_vld |-> sb_count != 0)
    else begin
      err_count = err_count + 1;
      $display("rd_vld is high although no word is left in the FIFO");
    end

  // head word is always the oldest one, so each pop gets it
  a_order : assert property (@(posedge rd_clk) disable iff (rd_rst)
    rd_vld |-> rd_data == exp_head)
    else begin
      err_count = err_count + 1;
      $display("FAILED rd_data expected %h got %h", $sampled(exp_head), $sampled(rd_data));
    end

  a_hold_vld : assert property (@(posedge rd_clk) disable iff (rd_rst)
    (rd_vld && !rd_en) |=> rd_vld)
    else begin
      err_count = err_count + 1;
      $display("rd_vld dropped although no word was popped");
    end

  a_hold_data : assert property (@(posedge rd_clk) disable iff (rd_rst)
    (rd_vld && !rd_en) |=> rd_data == held_data)
    else begin
      err_count = err_count + 1;
      $display("FAILED rd_data expected %h got %h", $sampled(held_data), $sampled(rd_data));
    end

  a_stream : assert property (@(posedge rd_clk) disable iff (rd_rst) stream_on |-> rd_vld)
    else begin
      err_count = err_count + 1;
      $display("streaming stalled, no word popped in this cycle");
    end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic step();
    @(posedge rd_clk);
    #2;                 // drive just after the edge
  endtask

  task automatic start_test();
    test_errs = err_count;
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_errs)
    begin
      pass_tests = pass_tests + 1;
      $display("test %s : pass", name);
    end
    else
    begin
      fail_tests = fail_tests + 1;
      $display("test %s : fail (%0d errors)", name, err_count - test_errs);
    end
  endtask

  task automatic wait_for_rd_vld(input int limit);
    int n;
    n = 0;
    while (!rd_vld && n < limit)
    begin
      step();
      n = n + 1;
    end
    if (!rd_vld)
    begin
      err_count = err_count + 1;
      $display("timed out waiting for rd_vld");
    end
  endtask

  task automatic drain_fifo();
    int n;
    n = 0;
    wr_en = 1'b0;
    rd_en = 1'b1;
    while (sb_count != 0 && n < t_drain)
    begin
      step();
      n = n + 1;
    end
    rd_en = 1'b0;
    if (sb_count != 0)
    begin
      err_count = err_count + 1;
      $display("timed out draining the FIFO, %0d words left", sb_count);
    end
    step();
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    int     n;
    integer r;
    rd_rst     = 1'b1;
    wr_data    = '0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    chk_reset  = 1'b0;
    stream_on  = 1'b0;
    err_count  = 0;
    pass_tests = 0;
    fail_tests = 0;
    test_errs  = 0;
    seed       = 44835;

    // reset state
    start_test();
    repeat (5) @(posedge rd_clk);
    #2;
    rd_rst    = 1'b0;
    chk_reset = 1'b1;   // sampled at the next edge
    step();
    chk_reset = 1'b0;
    step();
    finish_test("reset_state");

    // first-word fall-through
    start_test();
    wr_data = 16'ha5c3;
    wr_en   = 1'b1;
    step();
    wr_en = 1'b0;
    wait_for_rd_vld(t_fwft);
    drain_fifo();
    finish_test("first_word_fall_through");

    // fill to full with the reader idle
    start_test();
    n = 0;
    wr_en = 1'b1;
    while (wr_vld && n < t_fill)
    begin
      wr_data = 16'h1000 + n;
      step();
      n = n + 1;
    end
    wr_en = 1'b0;
    if (wr_vld)
    begin
      err_count = err_count + 1;
      $display("timed out filling the FIFO, wr_vld never fell");
    end
    step();
    drain_fifo();
    finish_test("fill_full_flags");

    // random traffic, write heavy first, read heavy second
    start_test();
    for (int i = 0; i < t_random; i++)
    begin
      r       = $random(seed);
      wr_data = r[31:16];
      if (i < t_random / 2)
      begin
        wr_en = (r[1:0] != 2'b00);
        rd_en = (r[3:2] == 2'b00);
      end
      else
      begin
        wr_en = (r[1:0] == 2'b00);
        rd_en = (r[3:2] != 2'b00);
      end
      step();
    end
    drain_fifo();
    finish_test("random_traffic");

    // streaming with writer and reader both busy
    start_test();
    n       = 0;
    wr_data = 16'h2000;
    wr_en   = 1'b1;
    rd_en   = 1'b1;
    while (!rd_vld && n < t_fwft)
    begin
      step();
      n       = n + 1;
      wr_data = 16'h2000 + n;
    end
    if (!rd_vld)
    begin
      err_count = err_count + 1;
      $display("timed out waiting for the stream to start");
    end
    stream_on = 1'b1;
    for (int i = 0; i < t_stream; i++)
    begin
      step();
      wr_data = wr_data + 1'b1;
    end
    stream_on = 1'b0;
    drain_fifo();
    finish_test("streaming");

    $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
             pass_tests, fail_tests, err_count);
    if (err_count == 0 && fail_tests == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // hard limit on run time
  initial
  begin
    #(total_cycles * clk_period * 2);
    $display("watchdog expired, the run took far longer than the tests need");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- prefetch_fifo.sv
/*
  prefetch (show-ahead) FIFO
  dual-port RAM with pointer controller, followed by a two-entry
  register stage; the prefetch logic keeps the next word already on
  rd_data before the reader asks for it
  capacity is 2^depth_width RAM words plus two in the output stage
*/
`timescale 1ns/10ps

module prefetch_fifo
#(
  parameter int depth_width = prefetch_fifo_pkg::def_depth_width,  // address width
  parameter int data_width  = prefetch_fifo_pkg::def_data_width,   // word width
  parameter int af_level    = (1 << depth_width) - 4,              // almost-full level
  parameter int ae_level    = 2                                    // almost-empty level
)
(
  input  logic                      rd_clk,        // fifo clock
  input  logic                      rd_rst,        // async reset, high
  input  logic [data_width-1:0]     wr_data,       // write word
  input  logic                      wr_en,         // writer pushes
  output logic                      wr_vld,        // RAM can take a word
  output logic [data_width-1:0]     rd_data,       // head word
  input  logic                      rd_en,         // reader pops
  output logic                      rd_vld,        // head word present
  output logic                      almost_full,   // RAM level flags
  output logic                      almost_empty,
  output prefetch_fifo_pkg::level_t water_level    // RAM words only
);

  logic [depth_width-1:0]        ram_waddr;    // from controller
  logic [depth_width-1:0]        ram_raddr;
  logic [data_width-1:0]         ram_rdata;    // registered RAM word
  logic                          ram_full;
  logic                          ram_empty;
  logic                          wr_strobe;    // accepted write
  logic                          pop;          // accepted read
  logic                          room;         // stage can take a word
  logic                          read_issue;   // RAM read this cycle
  logic                          load_valid;   // RAM word lands next edge
  prefetch_fifo_pkg::stage_occ_e occ_q;        // held plus in flight
  prefetch_fifo_pkg::stage_occ_e occ_nxt;

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_vld    = ~ram_full;
  assign wr_strobe = wr_en & wr_vld;   // gate with not-full

  //////////////////////////////
  // prefetch issue
  //////////////////////////////

  assign pop        = rd_en & rd_vld;
  assign room       = (occ_q != prefetch_fifo_pkg::occ_two) | pop;  // slot frees on pop
  assign read_issue = ~ram_empty & room;

  // tracker counts words held in the stage or on the way from RAM
  always_comb
  begin
    occ_nxt = occ_q;
    case ({read_issue, pop})
      2'b10:
        case (occ_q)
          prefetch_fifo_pkg::occ_none: occ_nxt = prefetch_fifo_pkg::occ_one;
          default:                     occ_nxt = prefetch_fifo_pkg::occ_two;
        endcase
      2'b01:
        case (occ_q)
          prefetch_fifo_pkg::occ_two: occ_nxt = prefetch_fifo_pkg::occ_one;
          default:                    occ_nxt = prefetch_fifo_pkg::occ_none;
        endcase
      default: occ_nxt = occ_q;  // both or neither
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      occ_q      <= prefetch_fifo_pkg::occ_none;
      load_valid <= 1'b0;
    end
    else
    begin
      occ_q      <= occ_nxt;
      load_valid <= read_issue;  // RAM data valid one cycle later
    end
  end

  //////////////////////////////
  // submodules
  //////////////////////////////

  sdp_ram #(
    .depth_width (depth_width),
    .data_width  (data_width)
  ) u_ram (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_en   (wr_strobe),
    .wr_addr (ram_waddr),
    .wr_data (wr_data),
    .rd_ce   (read_issue),
    .rd_addr (ram_raddr),
    .rd_data (ram_rdata)
  );

  fifo_ctrl #(
    .depth_width (depth_width),
    .af_level    (af_level),
    .ae_level    (ae_level)
  ) u_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .w_en         (wr_strobe),
    .r_en         (read_issue),
    .waddr        (ram_waddr),
    .raddr        (ram_raddr),
    .full         (ram_full),
    .empty        (ram_empty),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .water_level  (water_level)
  );

  out_reg_fifo #(
    .data_width (data_width)
  ) u_out (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .in_valid  (load_valid),
    .in_data   (ram_rdata),
    .out_ready (rd_en),
    .out_data  (rd_data),
    .out_valid (rd_vld)
  );

  // tracker must cover every word held or in flight
  // an undercount lets the stage overflow or pop below empty
  a_occ_bounds : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    ((occ_q != prefetch_fifo_pkg::occ_two) |-> !(rd_vld && load_valid)) and
    ((occ_q == prefetch_fifo_pkg::occ_none) |-> !(rd_vld || load_valid))
  ) else $error("prefetch_fifo: output tracker out of range");

endmodule

//--- out_reg_fifo.sv
/*
  two-entry register FIFO
  holds prefetched words at the output; the head word is always
  visible on out_data while out_valid is high
*/
`timescale 1ns/10ps

module out_reg_fifo
#(
  parameter int data_width = 16  // word width
)
(
  input  logic                  rd_clk,     // fifo clock
  input  logic                  rd_rst,     // async reset, high
  input  logic                  in_valid,   // word arriving from RAM
  input  logic [data_width-1:0] in_data,    // RAM read word
  input  logic                  out_ready,  // reader takes head
  output logic [data_width-1:0] out_data,   // head word
  output logic                  out_valid   // head word present
);

  prefetch_fifo_pkg::stage_occ_e occ_q;     // words held
  prefetch_fifo_pkg::stage_occ_e occ_nxt;
  logic [data_width-1:0]         head_q;    // word on the output
  logic [data_width-1:0]         tail_q;    // next word behind it
  logic                          pop;       // head leaves this edge
  logic                          head_free; // head can take a load
  logic                          load_head;
  logic                          load_tail;
  logic                          shift;     // tail moves to head

  assign out_valid = (occ_q != prefetch_fifo_pkg::occ_none);
  assign out_data  = head_q;
  assign pop       = out_ready & out_valid;

  assign head_free = (occ_q == prefetch_fifo_pkg::occ_none) |
                     ((occ_q == prefetch_fifo_pkg::occ_one) & pop);
  assign load_head = in_valid & head_free;
  assign load_tail = in_valid & ~head_free;
  assign shift     = pop & (occ_q == prefetch_fifo_pkg::occ_two);

  //////////////////////////////
  // occupancy
  //////////////////////////////

  always_comb
  begin
    occ_nxt = occ_q;
    case (occ_q)
      prefetch_fifo_pkg::occ_none:
        if (in_valid)
          occ_nxt = prefetch_fifo_pkg::occ_one;
      prefetch_fifo_pkg::occ_one:
        if (in_valid && !pop)
          occ_nxt = prefetch_fifo_pkg::occ_two;   // fill tail
        else if (!in_valid && pop)
          occ_nxt = prefetch_fifo_pkg::occ_none;  // drained
      default:
        if (pop && !in_valid)
          occ_nxt = prefetch_fifo_pkg::occ_one;   // tail -> head
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      occ_q <= prefetch_fifo_pkg::occ_none;
    else
      occ_q <= occ_nxt;
  end

  // payload registers
  always_ff @(posedge rd_clk)
  begin
    if (load_head)
      head_q <= in_data;   // straight to the output
    else if (shift)
      head_q <= tail_q;    // next word moves up
    if (load_tail)
      tail_q <= in_data;
  end

  // prefetch tracker upstream must never overfill the stage
  a_no_overflow : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    (occ_q == prefetch_fifo_pkg::occ_two && !pop) |-> !in_valid
  ) else $error("out_reg_fifo: load while full and not popped");

endmodule

//--- fifo_ctrl.sv
/*
  RAM pointer controller
  binary write and read pointers with one wrap bit give full and
  empty; a level counter tracks RAM words and drives the almost-full
  and almost-empty flags against their thresholds
*/
`timescale 1ns/10ps

module fifo_ctrl
#(
  parameter int depth_width = 4,    // address width
  parameter int af_level    = 12,   // almost full at or above this
  parameter int ae_level    = 2     // almost empty at or below this
)
(
  input  logic                      rd_clk,        // fifo clock
  input  logic                      rd_rst,        // async reset, high
  input  logic                      w_en,          // gated write strobe
  input  logic                      r_en,          // RAM read strobe
  output logic [depth_width-1:0]    waddr,         // RAM write address
  output logic [depth_width-1:0]    raddr,         // RAM read address
  output logic                      full,          // RAM holds 2^depth_width
  output logic                      empty,         // RAM holds nothing
  output logic                      almost_full,   // level >= af_level
  output logic                      almost_empty,  // level <= ae_level
  output prefetch_fifo_pkg::level_t water_level    // RAM word count
);

  localparam int ptr_width = depth_width + 1;  // address plus wrap bit

  logic [ptr_width-1:0]      wptr_q;     // write pointer
  logic [ptr_width-1:0]      rptr_q;     // read pointer
  prefetch_fifo_pkg::level_t level_q;    // current word count
  prefetch_fifo_pkg::level_t level_nxt;  // count after this edge
  logic                      af_q;       // registered flags
  logic                      ae_q;

  //////////////////////////////
  // pointers
  //////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wptr_q <= '0;
      rptr_q <= '0;
    end
    else
    begin
      if (w_en)
        wptr_q <= wptr_q + 1'b1;  // wraps through the extra bit
      if (r_en)
        rptr_q <= rptr_q + 1'b1;
    end
  end

  assign waddr = wptr_q[depth_width-1:0];  // drop wrap bit
  assign raddr = rptr_q[depth_width-1:0];

  // same address, wrap bits differ -> one full lap ahead
  assign full  = (wptr_q[depth_width] != rptr_q[depth_width]) &&
                 (wptr_q[depth_width-1:0] == rptr_q[depth_width-1:0]);
  assign empty = (wptr_q == rptr_q);

  //////////////////////////////
  // water level and flags
  //////////////////////////////

  always_comb
  begin
    level_nxt = level_q;
    case ({w_en, r_en})
      2'b10:   level_nxt = level_q + 1'b1;  // write only
      2'b01:   level_nxt = level_q - 1'b1;  // read only
      default: level_nxt = level_q;         // both or neither
    endcase
  end

  // flags are registered from the next level, so they always match
  // the level shown on water_level in the same cycle
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      level_q <= '0;
      af_q    <= 1'b0;
      ae_q    <= 1'b1;  // empty counts as almost empty
    end
    else
    begin
      level_q <= level_nxt;
      af_q    <= (level_nxt >= prefetch_fifo_pkg::level_t'(af_level));
      ae_q    <= (level_nxt <= prefetch_fifo_pkg::level_t'(ae_level));
    end
  end

  assign water_level  = level_q;
  assign almost_full  = af_q;
  assign almost_empty = ae_q;

  //////////////////////////////
  // checks
  //////////////////////////////

  // the top must gate writes with full
  a_no_write_full : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    w_en |-> !full
  ) else $error("fifo_ctrl: write strobe while full");

  // the prefetch logic must gate reads with empty
  a_no_read_empty : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    r_en |-> !empty
  ) else $error("fifo_ctrl: read strobe while empty");

endmodule

//--- sdp_ram.sv
/*
  simple dual-port RAM
  synchronous write port, synchronous read port with its own clock
  enable; read data updates only on an enabled read and is cleared
  by reset
*/
`timescale 1ns/10ps

module sdp_ram
#(
  parameter int depth_width = 4,   // address width
  parameter int data_width  = 16   // word width
)
(
  input  logic                   rd_clk,   // single clock for both ports
  input  logic                   rd_rst,   // clears read register only
  input  logic                   wr_en,    // write strobe
  input  logic [depth_width-1:0] wr_addr,  // write address
  input  logic [data_width-1:0]  wr_data,  // write word
  input  logic                   rd_ce,    // read clock enable
  input  logic [depth_width-1:0] rd_addr,  // read address
  output logic [data_width-1:0]  rd_data   // registered read word
);

  localparam int depth = 1 << depth_width;  // number of words

  logic [data_width-1:0] mem [0:depth-1];   // storage array

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;  // plain synchronous write
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // a write and a read to the same address in one cycle return the
  // old word; the controller never reads a slot written that cycle
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      rd_data <= '0;              // known value after reset
    else if (rd_ce)
      rd_data <= mem[rd_addr];    // hold otherwise
  end

endmodule

//--- prefetch_fifo_pkg.sv
/*
  prefetch fifo shared definitions
  default widths for the top level and testbench, the RAM water-level
  type and the occupancy encoding of the two-entry output stage
*/
package prefetch_fifo_pkg;

  //////////////////////////////
  // default geometry
  //////////////////////////////

  localparam int def_depth_width = 4;   // 16 RAM words
  localparam int def_data_width  = 16;  // word width
  localparam int max_depth_width = 12;  // largest address width supported

  //////////////////////////////
  // types
  //////////////////////////////

  // count of RAM words, 0 .. 2^depth_width inclusive, so one bit
  // wider than the largest address
  typedef logic [max_depth_width:0] level_t;

  // words held or in flight in the output stage
  typedef enum logic [1:0]
  {
    occ_none = 2'd0,  // stage empty
    occ_one  = 2'd1,  // one word
    occ_two  = 2'd2   // stage full
  } stage_occ_e;

endpackage
